//--- src/cart_header_probe_settings.svh
`ifndef CART_HEADER_PROBE_SETTINGS_SVH
`define CART_HEADER_PROBE_SETTINGS_SVH

////////////////////
// Loader stream

// Byte address width of the loader
`define CART_ADDR_W 25

////////////////////
// Header word addresses

// Product code, five words with the bytes swapped
`define HDR_ID_FIRST 'h182
`define HDR_ID_LAST 'h18A

// First write past the product code, starts the table lookup
`define HDR_ID_DONE 'h18C

// Region field
`define HDR_REGION_A 'h1F0
`define HDR_REGION_B 'h1F2

// End of the header block
`define HDR_END 'h200

////////////////////
// Defaults

// Sensor delay for titles with no gun entry
`define GUN_DELAY_DEFAULT 44

`endif

//--- src/cart_hdr_pkg.sv
package cart_hdr_pkg;

`include "cart_header_probe_settings.svh"

	////////////////////
	// Loader stream

	typedef logic [`CART_ADDR_W-1:0] cart_addr_t; // Byte address
	typedef logic [15:0] cart_word_t;
	typedef logic [7:0] ldr_index_t; // All ones marks a cheat download

	////////////////////
	// Header contents

	// Eight ASCII characters, first character in the top byte
	typedef logic [63:0] cart_id_t;

	// Bit positions within quirk_vec_t
	typedef enum logic [3:0] {
		qk_sram   = 4'd0,
		qk_sram00 = 4'd1,
		qk_eeprom = 4'd2,
		qk_noram  = 4'd3,
		qk_fifo   = 4'd4,
		qk_pier   = 4'd5,
		qk_svp    = 4'd6,
		qk_fmbusy = 4'd7,
		qk_schan  = 4'd8
	} quirk_idx_e;

	typedef logic [8:0] quirk_vec_t;

	// Light gun sensor delay in pixel clocks
	typedef logic [7:0] gun_delay_t;

endpackage

//--- src/region_pkg.sv
package region_pkg;

	// Value doubles as the bit index into hdr_marks_t
	typedef enum logic [1:0] {
		region_japan  = 2'd0,
		region_usa    = 2'd1,
		region_europe = 2'd2
	} region_e;

	typedef enum logic [1:0] {
		prio_us_eu_jp = 2'd0,
		prio_eu_us_jp = 2'd1,
		prio_us_jp_eu = 2'd2,
		prio_jp_us_eu = 2'd3
	} region_prio_e;

	typedef enum logic [1:0] {
		mode_from_header   = 2'd0,
		mode_from_file_ext = 2'd1,
		mode_disabled      = 2'd2
	} region_mode_e;

	// Seen regions, {europe, usa, japan}
	typedef logic [2:0] hdr_marks_t;

	typedef enum logic {
		rr_idle,
		rr_hold
	} resolver_state_e;

endpackage

//--- src/download_tracker.sv
`timescale 1ns/100ps

module download_tracker (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    ldr_download,
	input  logic                    ldr_wr,
	input  cart_hdr_pkg::cart_addr_t ldr_addr,
	input  cart_hdr_pkg::cart_word_t ldr_data,
	input  cart_hdr_pkg::ldr_index_t ldr_index,
	output logic                    hdr_wr,
	output cart_hdr_pkg::cart_addr_t hdr_addr,
	output cart_hdr_pkg::cart_word_t hdr_data,
	output logic                    dl_start,
	output logic                    dl_end,
	output cart_hdr_pkg::ldr_index_t file_index,
	output cart_hdr_pkg::cart_addr_t rom_size
);
	import cart_hdr_pkg::*;

	logic cart_download; // Download level without cheat files
	logic cart_download_q;
	logic dl_rise;
	logic dl_fall;

	assign cart_download = ldr_download && !(&ldr_index);
	assign dl_rise = cart_download && !cart_download_q;
	assign dl_fall = !cart_download && cart_download_q;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			cart_download_q <= 1'b0;
			hdr_wr <= 1'b0;
			dl_start <= 1'b0;
			dl_end <= 1'b0;
		end else begin
			cart_download_q <= cart_download;
			hdr_wr <= cart_download && ldr_wr;
			dl_start <= dl_rise;
			dl_end <= dl_fall;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cart_download && ldr_wr) begin
			hdr_addr <= ldr_addr;
			hdr_data <= ldr_data;
		end
		if (dl_rise) file_index <= ldr_index;
		if (dl_fall) rom_size <= hdr_addr; // Address of the last cartridge write
	end

	a_edges_apart: assert property (@(posedge clk_sys) disable iff (RESET)
		!(dl_start && dl_end));

endmodule

//--- src/header_scanner.sv
`timescale 1ns/100ps
`include "cart_header_probe_settings.svh"

module header_scanner (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    hdr_wr,
	input  cart_hdr_pkg::cart_addr_t hdr_addr,
	input  cart_hdr_pkg::cart_word_t hdr_data,
	input  logic                    dl_start,
	input  logic                    dl_end,
	output cart_hdr_pkg::cart_id_t   cart_id,
	output logic                    id_strobe,
	output region_pkg::hdr_marks_t   hdr_marks,
	output logic                    hdr_ready
);
	import cart_hdr_pkg::*;
	import region_pkg::*;

	localparam cart_addr_t addr_id_0 = cart_addr_t'(`HDR_ID_FIRST);
	localparam cart_addr_t addr_id_1 = addr_id_0 + cart_addr_t'(2);
	localparam cart_addr_t addr_id_2 = addr_id_0 + cart_addr_t'(4);
	localparam cart_addr_t addr_id_3 = addr_id_0 + cart_addr_t'(6);
	localparam cart_addr_t addr_id_4 = cart_addr_t'(`HDR_ID_LAST);
	localparam cart_addr_t addr_id_done = cart_addr_t'(`HDR_ID_DONE);
	localparam cart_addr_t addr_region_a = cart_addr_t'(`HDR_REGION_A);
	localparam cart_addr_t addr_region_b = cart_addr_t'(`HDR_REGION_B);
	localparam cart_addr_t addr_end = cart_addr_t'(`HDR_END);

	logic [7:0] lo_byte;
	logic [7:0] hi_byte;
	logic [3:0] hrgn; // Hex digit A..F as its value 10..15
	hdr_marks_t marks_next;

	assign lo_byte = hdr_data[7:0];
	assign hi_byte = hdr_data[15:8];
	assign hrgn = lo_byte[3:0] - 4'd7;

	// Single region letter to its mark
	function automatic hdr_marks_t letter_mark(input logic [7:0] c);
		hdr_marks_t m;
		m = '0;
		case (c)
			"J": m[region_japan] = 1'b1;
			"U": m[region_usa] = 1'b1;
			"E": m[region_europe] = 1'b1;
			default: m = '0;
		endcase
		return m;
	endfunction

	////////////////////
	// Region marks

	always_comb begin
		marks_next = dl_start ? '0 : hdr_marks;
		if (hdr_wr && hdr_addr == addr_region_a) begin
			if (letter_mark(lo_byte) != '0)
				marks_next = marks_next | letter_mark(lo_byte);
			else if (lo_byte >= "0" && lo_byte <= "9")
				marks_next = {lo_byte[3], lo_byte[2], lo_byte[0]}; // Coded form
			else if (lo_byte >= "A" && lo_byte <= "F")
				marks_next = {hrgn[3], hrgn[2], hrgn[0]};
			marks_next = marks_next | letter_mark(hi_byte); // High byte adds on top
		end
		if (hdr_wr && hdr_addr == addr_region_b)
			marks_next = marks_next | letter_mark(lo_byte);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			hdr_marks <= '0;
			id_strobe <= 1'b0;
			hdr_ready <= 1'b0;
		end else begin
			hdr_marks <= marks_next;
			id_strobe <= hdr_wr && hdr_addr == addr_id_done;
			if (dl_end)
				hdr_ready <= 1'b0;
			else if (hdr_wr && hdr_addr == addr_end)
				hdr_ready <= 1'b1;
		end
	end

	////////////////////
	// Product code

	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			case (hdr_addr)
				addr_id_0: cart_id[63:56] <= hi_byte;
				addr_id_1: cart_id[55:40] <= {lo_byte, hi_byte};
				addr_id_2: cart_id[39:24] <= {lo_byte, hi_byte};
				addr_id_3: cart_id[23:8] <= {lo_byte, hi_byte};
				addr_id_4: cart_id[7:0] <= lo_byte;
				default: ;
			endcase
		end
	end

	a_id_before_end: assert property (@(posedge clk_sys) disable iff (RESET)
		!(id_strobe && hdr_ready));

endmodule

//--- src/quirk_lookup.sv
`timescale 1ns/100ps
`include "cart_header_probe_settings.svh"

module quirk_lookup (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  logic                      dl_start,
	input  cart_hdr_pkg::cart_id_t     cart_id,
	input  logic                      id_strobe,
	output cart_hdr_pkg::quirk_vec_t   quirks,
	output logic                      gun_type,
	output cart_hdr_pkg::gun_delay_t   gun_delay
);
	import cart_hdr_pkg::*;

	typedef struct packed {
		cart_id_t   id;
		quirk_idx_e idx;
	} quirk_entry_t;

	typedef struct packed {
		cart_id_t   id;
		logic       kind;
		gun_delay_t delay;
	} gun_entry_t;

	localparam int quirk_count = 25;
	localparam int gun_count = 5;
	localparam logic [7:0] wild_char = "?";
	localparam gun_delay_t delay_default = gun_delay_t'(`GUN_DELAY_DEFAULT);

	// First match wins
	localparam quirk_entry_t quirk_table [quirk_count] = '{
		'{"T-081276", qk_sram}, '{"T-81406 ", qk_sram}, '{"T-081586", qk_sram},
		'{"T-81576 ", qk_sram}, '{"T-81476 ", qk_sram},
		'{"MK-1215 ", qk_eeprom}, '{"G-4060  ", qk_eeprom}, '{"00001211", qk_eeprom},
		'{"MK-1228 ", qk_eeprom}, '{"G-5538  ", qk_eeprom}, '{"00004076", qk_eeprom},
		'{"T-12046 ", qk_eeprom}, '{"T-12053 ", qk_eeprom}, '{"G-4524  ", qk_eeprom},
		'{"T-113016", qk_noram}, // Fake RAM check
		'{"T-89016 ", qk_fifo},
		'{"T-574023", qk_pier}, '{"T-574013", qk_pier},
		'{"MK-1229 ", qk_svp}, '{"G-7001  ", qk_svp},
		'{"T-35036 ", qk_fmbusy}, '{"T-25073 ", qk_fmbusy}, '{"MK-1137-", qk_fmbusy},
		'{"T-68???-", qk_schan}, // Whole series under one code
		'{" GM 0000", qk_sram00}
	};

	localparam gun_entry_t gun_table [gun_count] = '{
		'{"MK-1533 ", 1'b0, 8'd100},
		'{"T-95096-", 1'b1, 8'd52},
		'{"T-95136-", 1'b1, 8'd30},
		'{"MK-1658 ", 1'b0, 8'd120},
		'{"T-081156", 1'b0, 8'd126}
	};

	quirk_vec_t quirk_hit;
	logic       quirk_found;
	logic       gun_hit_type;
	gun_delay_t gun_hit_delay;
	logic       gun_found;

	// Compare by character, ? in the pattern matches anything
	function automatic logic id_match(input cart_id_t id, input cart_id_t pattern);
		logic hit;
		hit = 1'b1;
		for (int b = 0; b < 8; b++) begin
			if (pattern[b*8 +: 8] != wild_char && pattern[b*8 +: 8] != id[b*8 +: 8])
				hit = 1'b0;
		end
		return hit;
	endfunction

	always_comb begin
		quirk_hit = '0;
		quirk_found = 1'b0;
		gun_hit_type = 1'b0;
		gun_hit_delay = delay_default;
		gun_found = 1'b0;
		for (int i = 0; i < quirk_count; i++) begin
			if (!quirk_found && id_match(cart_id, quirk_table[i].id)) begin
				quirk_found = 1'b1;
				quirk_hit[quirk_table[i].idx] = 1'b1;
			end
		end
		for (int i = 0; i < gun_count; i++) begin
			if (!gun_found && cart_id == gun_table[i].id) begin
				gun_found = 1'b1;
				gun_hit_type = gun_table[i].kind;
				gun_hit_delay = gun_table[i].delay;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			quirks <= '0;
			gun_type <= 1'b0;
			gun_delay <= delay_default;
		end else begin
			if (dl_start) quirks <= '0; // New cartridge
			if (id_strobe) begin
				quirks <= quirk_hit;
				gun_type <= gun_hit_type;
				gun_delay <= gun_hit_delay;
			end
		end
	end

	a_one_quirk: assert property (@(posedge clk_sys) disable iff (RESET) $onehot0(quirks));

endmodule

//--- src/region_resolver.sv
`timescale 1ns/100ps

module region_resolver (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  logic                      hdr_ready,
	input  region_pkg::hdr_marks_t     hdr_marks,
	input  cart_hdr_pkg::ldr_index_t   file_index,
	input  region_pkg::region_mode_e   region_mode,
	input  region_pkg::region_prio_e   region_prio,
	output logic                      region_set,
	output region_pkg::region_e        region_req
);
	import region_pkg::*;

	resolver_state_e state;
	logic            ready_q;
	logic            take; // Header just completed and a request is wanted

	assign take = state == rr_idle && hdr_ready && !ready_q && region_mode != mode_disabled;

	// First marked region in the given order, else the order's leader
	function automatic region_e pick_region(input hdr_marks_t marks, input region_prio_e prio);
		region_e order [3];
		region_e pick;
		case (prio)
			prio_eu_us_jp: order = '{region_europe, region_usa, region_japan};
			prio_us_jp_eu: order = '{region_usa, region_japan, region_europe};
			prio_jp_us_eu: order = '{region_japan, region_usa, region_europe};
			default: order = '{region_usa, region_europe, region_japan};
		endcase
		pick = order[0];
		for (int i = 2; i >= 0; i--) begin
			if (marks[order[i]]) pick = order[i]; // Region value is its mark bit
		end
		return pick;
	endfunction

	////////////////////
	// Resolver FSM

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state <= rr_idle;
			ready_q <= 1'b0;
			region_set <= 1'b0;
		end else begin
			ready_q <= hdr_ready;
			case (state)
				rr_idle: begin
					if (take) begin
						state <= rr_hold;
						if (region_mode == mode_from_file_ext)
							region_set <= |file_index; // Index 0 means no extension hint
						else
							region_set <= 1'b1;
					end
				end
				rr_hold: begin
					if (!hdr_ready) begin // Download over
						state <= rr_idle;
						region_set <= 1'b0;
					end
				end
				default: state <= rr_idle;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take) begin
			if (region_mode == mode_from_file_ext)
				region_req <= region_e'(file_index[7:6]);
			else
				region_req <= pick_region(hdr_marks, region_prio);
		end
	end

	a_no_set_disabled: assert property (@(posedge clk_sys) disable iff (RESET)
		region_set |-> region_mode != mode_disabled);

endmodule

//--- src/cart_header_probe.sv
`timescale 1ns/100ps

module cart_header_probe (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  logic                      ldr_download,
	input  logic                      ldr_wr,
	input  cart_hdr_pkg::cart_addr_t   ldr_addr,
	input  cart_hdr_pkg::cart_word_t   ldr_data,
	input  cart_hdr_pkg::ldr_index_t   ldr_index,
	input  region_pkg::region_mode_e   region_mode,
	input  region_pkg::region_prio_e   region_prio,
	output cart_hdr_pkg::cart_addr_t   rom_size,
	output cart_hdr_pkg::quirk_vec_t   quirks,
	output logic                      gun_type,
	output cart_hdr_pkg::gun_delay_t   gun_delay,
	output logic                      region_set,
	output region_pkg::region_e        region_req
);
	import cart_hdr_pkg::*;
	import region_pkg::*;

	// Tracker to scanner
	logic       hdr_wr;
	cart_addr_t hdr_addr;
	cart_word_t hdr_data;
	logic       dl_start;
	logic       dl_end;
	ldr_index_t file_index;

	// Scanner to lookup and resolver
	cart_id_t   cart_id;
	logic       id_strobe;
	hdr_marks_t hdr_marks;
	logic       hdr_ready;

	download_tracker u_download_tracker (.clk_sys(clk_sys), .RESET(RESET),
		.ldr_download(ldr_download), .ldr_wr(ldr_wr), .ldr_addr(ldr_addr),
		.ldr_data(ldr_data), .ldr_index(ldr_index), .hdr_wr(hdr_wr), .hdr_addr(hdr_addr),
		.hdr_data(hdr_data), .dl_start(dl_start), .dl_end(dl_end),
		.file_index(file_index), .rom_size(rom_size));

	header_scanner u_header_scanner (.clk_sys(clk_sys), .RESET(RESET), .hdr_wr(hdr_wr),
		.hdr_addr(hdr_addr), .hdr_data(hdr_data), .dl_start(dl_start), .dl_end(dl_end),
		.cart_id(cart_id), .id_strobe(id_strobe), .hdr_marks(hdr_marks),
		.hdr_ready(hdr_ready));

	quirk_lookup u_quirk_lookup (.clk_sys(clk_sys), .RESET(RESET), .dl_start(dl_start),
		.cart_id(cart_id), .id_strobe(id_strobe), .quirks(quirks), .gun_type(gun_type),
		.gun_delay(gun_delay));

	region_resolver u_region_resolver (.clk_sys(clk_sys), .RESET(RESET),
		.hdr_ready(hdr_ready), .hdr_marks(hdr_marks), .file_index(file_index),
		.region_mode(region_mode), .region_prio(region_prio), .region_set(region_set),
		.region_req(region_req));

endmodule

//--- tests/cart_ref_model.svh
`ifndef CART_REF_MODEL_SVH
`define CART_REF_MODEL_SVH

////////////////////
// Title tables

localparam int quirk_count = 25;
localparam int gun_count = 5;

localparam cart_id_t quirk_codes [quirk_count] = '{
	"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ",
	"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
	"00004076", "T-12046 ", "T-12053 ", "G-4524  ",
	"T-113016", "T-89016 ", "T-574023", "T-574013", "MK-1229 ", "G-7001  ",
	"T-35036 ", "T-25073 ", "MK-1137-", "T-68???-", " GM 0000"
};

// Quirk bit of each code above
localparam int quirk_bits [quirk_count] = '{
	0, 0, 0, 0, 0, 2, 2, 2, 2, 2, 2, 2, 2, 2, 3, 4, 5, 5, 6, 6, 7, 7, 7, 8, 1
};

localparam cart_id_t gun_codes [gun_count] = '{
	"MK-1533 ", "T-95096-", "T-95136-", "MK-1658 ", "T-081156"
};
localparam logic gun_kinds [gun_count] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0};
localparam int gun_delays [gun_count] = '{100, 52, 30, 120, 126};

////////////////////
// Region decode

function automatic hdr_marks_t letter_region(input logic [7:0] c);
	case (c)
		"J": return 3'b001;
		"U": return 3'b010;
		"E": return 3'b100;
		default: return 3'b000;
	endcase
endfunction

// Bytes 1F0, 1F1 and 1F2 of the image
function automatic hdr_marks_t expected_marks(input logic [7:0] c0, input logic [7:0] c1,
	input logic [7:0] c2);
	hdr_marks_t m;
	logic [3:0] nib;
	m = letter_region(c0);
	if (m == 3'b000 && c0 >= "0" && c0 <= "9") begin
		m = {c0[3], c0[2], c0[0]}; // Digit form, europe usa japan
	end else if (m == 3'b000 && c0 >= "A" && c0 <= "F") begin
		nib = c0[3:0] - 4'd7;
		m = {nib[3], nib[2], nib[0]};
	end
	return m | letter_region(c1) | letter_region(c2);
endfunction

function automatic logic [1:0] expected_region(input hdr_marks_t marks,
	input region_prio_e prio);
	logic [5:0] order; // First choice in the top two bits
	case (prio)
		prio_us_eu_jp: order = {region_usa, region_europe, region_japan};
		prio_eu_us_jp: order = {region_europe, region_usa, region_japan};
		prio_us_jp_eu: order = {region_usa, region_japan, region_europe};
		default: order = {region_japan, region_usa, region_europe};
	endcase
	for (int i = 2; i >= 0; i--) begin
		if (marks[order[i*2 +: 2]]) return order[i*2 +: 2];
	end
	return order[5:4]; // No mark at all
endfunction

////////////////////
// Title lookup

function automatic logic code_matches(input cart_id_t id, input cart_id_t pattern);
	for (int i = 0; i < 8; i++) begin
		if (pattern[i*8 +: 8] != "?" && pattern[i*8 +: 8] != id[i*8 +: 8]) return 1'b0;
	end
	return 1'b1;
endfunction

task automatic expected_lookup(input cart_id_t id, output quirk_vec_t q, output logic kind,
	output gun_delay_t delay);
	logic found;
	q = '0;
	found = 1'b0;
	kind = 1'b0;
	delay = gun_delay_t'(`GUN_DELAY_DEFAULT);
	for (int i = 0; i < quirk_count; i++) begin
		if (!found && code_matches(id, quirk_codes[i])) begin
			found = 1'b1; // Earlier entry wins
			q[quirk_bits[i]] = 1'b1;
		end
	end
	for (int i = 0; i < gun_count; i++) begin
		if (id == gun_codes[i]) begin
			kind = gun_kinds[i];
			delay = gun_delay_t'(gun_delays[i]);
		end
	end
endtask

`endif

//--- tests/tb_cart_header_probe.sv
`timescale 1ns/100ps
`include "cart_header_probe_settings.svh"

module tb_cart_header_probe;
	import cart_hdr_pkg::*;
	import region_pkg::*;

	localparam int image_count = 40;
	localparam int cycles_per_image = 1200;
	localparam int wait_limit = 32; // Cycles allowed for region_set to move

	logic         clk_sys;
	logic         RESET;
	logic         ldr_download;
	logic         ldr_wr;
	cart_addr_t   ldr_addr;
	cart_word_t   ldr_data;
	ldr_index_t   ldr_index;
	region_mode_e region_mode;
	region_prio_e region_prio;
	cart_addr_t   rom_size;
	quirk_vec_t   quirks;
	logic         gun_type;
	gun_delay_t   gun_delay;
	logic         region_set;
	region_e      region_req;

	int          errors;
	int          checks;
	logic [31:0] lcg_state;
	cart_id_t    code; // Product code of the image in flight
	logic [7:0]  rgn_c [3]; // Region field bytes

`include "cart_ref_model.svh"

	cart_header_probe u_cart_header_probe (
		.clk_sys(clk_sys), .RESET(RESET), .ldr_download(ldr_download), .ldr_wr(ldr_wr),
		.ldr_addr(ldr_addr), .ldr_data(ldr_data), .ldr_index(ldr_index),
		.region_mode(region_mode), .region_prio(region_prio), .rom_size(rom_size),
		.quirks(quirks), .gun_type(gun_type), .gun_delay(gun_delay),
		.region_set(region_set), .region_req(region_req)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	function automatic int unsigned next_rand(input int unsigned range);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {16'd0, lcg_state[30:15]} % range;
	endfunction

	function automatic logic [7:0] random_letter();
		case (next_rand(3))
			0: return "J";
			1: return "U";
			default: return "E";
		endcase
	endfunction

	// Loader word w carries image bytes w and w+1, the latter on top
	function automatic logic [7:0] image_byte(input int a);
		if (a > `HDR_ID_FIRST && a <= `HDR_ID_LAST)
			return code[63 - 8 * (a - `HDR_ID_FIRST - 1) -: 8];
		if (a >= `HDR_REGION_A && a <= `HDR_REGION_A + 2)
			return rgn_c[a - `HDR_REGION_A];
		return 8'(next_rand(256));
	endfunction

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic wait_region_level(input logic level, output logic seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < wait_limit) begin
			@(negedge clk_sys);
			seen = (region_set === level);
			n++;
		end
	endtask

	////////////////////
	// Image contents

	task automatic make_code();
		int unsigned r;
		r = next_rand(3);
		if (r == 0) begin
			for (int i = 0; i < 8; i++) begin
				r = next_rand(43);
				code[i*8 +: 8] = 8'h30 + r[7:0]; // Digits and capitals
			end
		end else begin
			r = next_rand(quirk_count + gun_count);
			code = (r < quirk_count) ? quirk_codes[r] : gun_codes[r - quirk_count];
			for (int i = 0; i < 8; i++) begin
				if (code[i*8 +: 8] == "?") begin
					r = next_rand(10);
					code[i*8 +: 8] = "0" + r[7:0];
				end
			end
		end
	endtask

	task automatic make_region_bytes(input logic blank);
		int unsigned r;
		r = next_rand(6);
		case (r)
			1: rgn_c[0] = "0" + 8'(next_rand(10));
			2: rgn_c[0] = "A" + 8'(next_rand(6));
			3: rgn_c[0] = " ";
			4: rgn_c[0] = 8'(next_rand(256));
			default: rgn_c[0] = random_letter();
		endcase
		rgn_c[1] = (next_rand(2) == 0) ? random_letter() : " ";
		rgn_c[2] = (next_rand(2) == 0) ? random_letter() : " ";
		if (blank) begin
			rgn_c[0] = " "; // No region at all
			rgn_c[1] = " ";
			rgn_c[2] = " ";
		end
	endtask

	////////////////////
	// One download

	task automatic run_image(input int num);
		int unsigned  r;
		int           last;
		int           gap;
		logic         cheat;
		logic         seen;
		ldr_index_t   idx;
		region_mode_e mode;
		region_prio_e prio;
		quirk_vec_t   exp_q;
		logic         exp_type;
		gun_delay_t   exp_delay;
		logic         exp_set;
		logic [1:0]   exp_req;
		cart_addr_t   old_size;
		quirk_vec_t   old_q;
		logic         old_type;
		gun_delay_t   old_delay;
		logic [1:0]   old_req;

		cheat = (num % 8 == 5);
		if (num % 5 < 3) mode = mode_from_header;
		else if (num % 5 == 3) mode = mode_from_file_ext;
		else mode = mode_disabled;
		r = num % 4;
		prio = region_prio_e'(r[1:0]);
		r = next_rand(4);
		if (cheat) begin
			idx = 8'hFF;
		end else if (r == 0) begin
			idx = 8'h00;
		end else begin
			r = next_rand(255);
			idx = r[7:0];
		end
		r = next_rand(64);
		last = 'h210 + 2 * int'(r); // Random tail past the header
		make_code();
		make_region_bytes(num % 7 == 2);

		expected_lookup(code, exp_q, exp_type, exp_delay);
		if (mode == mode_from_file_ext) begin
			exp_req = idx[7:6];
			exp_set = |idx;
		end else begin
			exp_req = expected_region(expected_marks(rgn_c[0], rgn_c[1], rgn_c[2]), prio);
			exp_set = (mode == mode_from_header);
		end
		old_size = rom_size;
		old_q = quirks;
		old_type = gun_type;
		old_delay = gun_delay;
		old_req = region_req;

		@(posedge clk_sys);
		region_mode <= mode;
		region_prio <= prio;
		ldr_index <= idx;
		ldr_download <= 1'b1;
		for (int a = 0; a <= last; a += 2) begin
			gap = (next_rand(4) == 0) ? int'(next_rand(3)) + 1 : 0;
			repeat (gap) begin
				@(posedge clk_sys);
				ldr_wr <= 1'b0;
			end
			@(posedge clk_sys);
			ldr_wr <= 1'b1;
			ldr_addr <= cart_addr_t'(a);
			ldr_data <= {image_byte(a + 1), image_byte(a)};
		end
		@(posedge clk_sys);
		ldr_wr <= 1'b0;

		if (!cheat) begin
			if (exp_set) begin
				wait_region_level(1'b1, seen);
				checks++;
				assert (seen) else begin
					errors++;
					$display("region_set did not rise after the header in image %0d", num);
				end
			end else begin
				@(negedge clk_sys);
				check_equal("region_set", 32'(region_set), 32'(0));
			end
			if (mode != mode_disabled)
				check_equal("region_req", 32'(region_req), 32'(exp_req));
			check_equal("quirks", 32'(quirks), 32'(exp_q));
			check_equal("gun_type", 32'(gun_type), 32'(exp_type));
			check_equal("gun_delay", 32'(gun_delay), 32'(exp_delay));
		end

		@(posedge clk_sys);
		ldr_download <= 1'b0;
		repeat (2) @(negedge clk_sys); // rom_size lands one cycle after the fall
		check_equal("rom_size", 32'(rom_size), cheat ? 32'(old_size) : 32'(last));
		wait_region_level(1'b0, seen);
		checks++;
		assert (seen) else begin
			errors++;
			$display("region_set stayed high after download %0d ended", num);
		end
		if (cheat) begin // Cheat file leaves everything alone
			check_equal("quirks", 32'(quirks), 32'(old_q));
			check_equal("gun_type", 32'(gun_type), 32'(old_type));
			check_equal("gun_delay", 32'(gun_delay), 32'(old_delay));
			check_equal("region_req", 32'(region_req), 32'(old_req));
		end
		repeat (4) @(posedge clk_sys);
	endtask

	always @(negedge clk_sys) begin
		if (!RESET && region_mode == mode_disabled) begin
			assert (!region_set) else begin
				errors++;
				$display("region_set is high while the region mode is disabled");
			end
		end
	end

	initial begin
		repeat (image_count * cycles_per_image) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles", image_count * cycles_per_image);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		errors = 0;
		checks = 0;
		lcg_state = 32'he95f;
		RESET = 1'b1;
		ldr_download = 1'b0;
		ldr_wr = 1'b0;
		ldr_addr = '0;
		ldr_data = '0;
		ldr_index = '0;
		region_mode = mode_from_header;
		region_prio = prio_us_eu_jp;
		repeat (8) @(posedge clk_sys);
		RESET <= 1'b0;
		@(negedge clk_sys);
		check_equal("quirks", 32'(quirks), 32'(0));
		check_equal("region_set", 32'(region_set), 32'(0));
		check_equal("gun_delay", 32'(gun_delay), 32'(`GUN_DELAY_DEFAULT));
		for (int n = 0; n < image_count; n++) run_image(n);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- cart_header_probe.f
+incdir+src
+incdir+tests
src/cart_hdr_pkg.sv
src/region_pkg.sv
src/download_tracker.sv
src/header_scanner.sv
src/quirk_lookup.sv
src/region_resolver.sv
src/cart_header_probe.sv
tests/tb_cart_header_probe.sv

//--- Makefile
VERILATOR  := verilator
TOP        := tb_cart_header_probe
FILELIST   := cart_header_probe.f
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
